//--- wb2sdrc_config.svh
`ifndef WB2SDRC_CONFIG_SVH
`define WB2SDRC_CONFIG_SVH

// --------------------------------------------------------------------------
// Bridge sizing
// --------------------------------------------------------------------------

// Wishbone and SDRAM data width, multiple of 8
`define WB2SDRC_DW 32

// Application address width seen by the controller
`define WB2SDRC_AW 26

// Entries per FIFO
`define WB2SDRC_CMD_DEPTH 4
`define WB2SDRC_WRDATA_DEPTH 8
`define WB2SDRC_RDDATA_DEPTH 4

`endif

//--- sdr_cmd_pkg.sv
`include "wb2sdrc_config.svh"

// --------------------------------------------------------------------------
// Request side of the SDRAM controller
// --------------------------------------------------------------------------

package sdr_cmd_pkg;

	// One request as queued in the command FIFO
	// Always a single transfer, so no length field
	typedef struct packed {
		// 0 for write, 1 for read
		logic                   wr_n;
		// Word address in the controller's space
		logic [`WB2SDRC_AW-1:0] addr;
	} sdr_cmd_t;

endpackage

//--- sdr_data_pkg.sv
`include "wb2sdrc_config.svh"

// --------------------------------------------------------------------------
// Data beats between the bridge and the SDRAM controller
// --------------------------------------------------------------------------

package sdr_data_pkg;

	// Write beat, byte mask kept next to the data
	typedef struct packed {
		// Active low, one bit per byte lane
		logic [`WB2SDRC_DW/8-1:0] wr_en_n;
		logic [`WB2SDRC_DW-1:0]   data;
	} wr_beat_t;

	// Read beat returned by the controller
	// End-of-burst marker not carried, every read is one word
	typedef struct packed {
		logic [`WB2SDRC_DW-1:0] data;
	} rd_beat_t;

endpackage

//--- fifo_if.sv
`timescale 1ns/1ps

// Push/pop bundle around one FIFO
// Payload type set per instance
interface fifo_if #(
	parameter type payload_t = logic
);

	// Write side
	logic     push;
	payload_t push_data;
	logic     full;

	// Read side, head entry shown without a pop
	logic     pop;
	payload_t pop_data;
	logic     empty;

	// Block that fills the FIFO
	modport producer (
		output push,
		output push_data,
		input  full
	);

	// The FIFO itself
	modport storage (
		input  push,
		input  push_data,
		output full,
		input  pop,
		output pop_data,
		output empty
	);

	// Block that drains the FIFO
	modport consumer (
		output pop,
		input  pop_data,
		input  empty
	);

endinterface

//--- sync_fifo.sv
`timescale 1ns/1ps

// First-word-fall-through FIFO, single clock
// Callers never push when full or pop when empty
module sync_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
) (
	input  logic     sdram_clk,
	input  logic     wb_clk_i,
	fifo_if.storage  q
);

	// Pointer wide enough for DEPTH entries, count for 0..DEPTH
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t           mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;

	// Wrap at DEPTH, so depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// ----------------------------------------------------------------------------
	// Storage
	// ----------------------------------------------------------------------------

	// Entry lands at the edge, visible at the head next cycle
	always_ff @(posedge sdram_clk) begin
		if (q.push)
			mem[wr_ptr] <= q.push_data;
	end

	// Head entry presented without waiting for a pop
	assign q.pop_data = mem[rd_ptr];

	// ----------------------------------------------------------------------------
	// Pointers and occupancy
	// ----------------------------------------------------------------------------

	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (q.push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (q.pop)
				rd_ptr <= ptr_inc(rd_ptr);
			// Simultaneous push and pop leaves count alone
			case ({q.push, q.pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Flags straight from the count
	assign q.empty = (count == '0);
	assign q.full  = (count == CNT_W'(DEPTH));

endmodule

//--- wb_slave_ctrl.sv
`timescale 1ns/1ps
`include "wb2sdrc_config.svh"

// Wishbone slave side of the bridge
// Turns bus cycles into command and write-data pushes, drains read data
module wb_slave_ctrl
	import sdr_cmd_pkg::*;
	import sdr_data_pkg::*;
(
	input  logic                     sdram_clk,
	input  logic                     wb_clk_i,

	// Wishbone slave
	input  logic                     wb_stb_i,
	input  logic                     wb_cyc_i,
	input  logic                     wb_we_i,
	input  logic [`WB2SDRC_AW-1:0]   wb_addr_i,
	input  logic [`WB2SDRC_DW-1:0]   wb_dat_i,
	input  logic [`WB2SDRC_DW/8-1:0] wb_sel_i,
	output logic                     wb_ack_o,
	output logic [`WB2SDRC_DW-1:0]   wb_dat_o,

	// FIFO sides
	fifo_if.producer                 cmd_q,
	fifo_if.producer                 wrdata_q,
	fifo_if.consumer                 rddata_q
);

	logic     wr_req;
	logic     rd_req;
	logic     rd_cmd_push;
	logic     pending_read;
	sdr_cmd_t cmd_word;
	wr_beat_t wr_beat;
	rd_beat_t rd_beat;

	// Active bus cycle split by direction
	assign wr_req = wb_stb_i & wb_cyc_i & wb_we_i;
	assign rd_req = wb_stb_i & wb_cyc_i & ~wb_we_i;

	// ----------------------------------------------------------------------------
	// Acknowledge
	// ----------------------------------------------------------------------------

	// Write: room for both command and data
	// Read: returned data already waiting
	always_comb begin
		if (wr_req)
			wb_ack_o = ~cmd_q.full & ~wrdata_q.full;
		else if (rd_req)
			wb_ack_o = ~rddata_q.empty;
		else
			wb_ack_o = 1'b0;
	end

	// ----------------------------------------------------------------------------
	// Command push
	// ----------------------------------------------------------------------------

	// Only one read command per held strobe
	assign rd_cmd_push = rd_req & ~cmd_q.full & ~pending_read;

	assign cmd_word.wr_n = ~wb_we_i;
	assign cmd_word.addr = wb_addr_i;

	assign cmd_q.push      = (wr_req & wb_ack_o) | rd_cmd_push;
	assign cmd_q.push_data = cmd_word;

	// Set once the read command is queued, cleared by the read ack
	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i)
			pending_read <= 1'b0;
		else if (rd_cmd_push)
			pending_read <= 1'b1;
		else if (rd_req & wb_ack_o)
			pending_read <= 1'b0;
	end

	// ----------------------------------------------------------------------------
	// Write data and read data
	// ----------------------------------------------------------------------------

	// Controller wants active-low byte enables
	assign wr_beat.wr_en_n = ~wb_sel_i;
	assign wr_beat.data    = wb_dat_i;

	// Ack already covers the full check
	assign wrdata_q.push      = wr_req & wb_ack_o;
	assign wrdata_q.push_data = wr_beat;

	// Head of the read FIFO goes out with the ack, then is dropped
	assign rd_beat      = rddata_q.pop_data;
	assign wb_dat_o     = rd_beat.data;
	assign rddata_q.pop = rd_req & wb_ack_o;

endmodule

//--- wb2sdrc.sv
`timescale 1ns/1ps
`include "wb2sdrc_config.svh"

// Wishbone slave to SDRAM controller request bridge
// Single clock, three FIFOs between the bus and the controller
module wb2sdrc
	import sdr_cmd_pkg::*;
	import sdr_data_pkg::*;
(
	input  logic                     sdram_clk,
	// Asynchronous reset, active high
	input  logic                     wb_clk_i,

	// ------------------------------------------------------------------------
	// Wishbone slave
	// ------------------------------------------------------------------------
	input  logic                     wb_stb_i,
	input  logic                     wb_cyc_i,
	// 1 write, 0 read
	input  logic                     wb_we_i,
	input  logic [`WB2SDRC_AW-1:0]   wb_addr_i,
	input  logic [`WB2SDRC_DW-1:0]   wb_dat_i,
	// Byte selects
	input  logic [`WB2SDRC_DW/8-1:0] wb_sel_i,
	output logic                     wb_ack_o,
	output logic [`WB2SDRC_DW-1:0]   wb_dat_o,

	// ------------------------------------------------------------------------
	// SDRAM controller requests
	// ------------------------------------------------------------------------
	output logic                     sdr_req_o,
	output logic [`WB2SDRC_AW-1:0]   sdr_req_addr_o,
	// 0 write, 1 read
	output logic                     sdr_req_wr_n_o,
	input  logic                     sdr_req_ack_i,

	// Write path, byte enables active low
	output logic [`WB2SDRC_DW/8-1:0] sdr_wr_en_n_o,
	output logic [`WB2SDRC_DW-1:0]   sdr_wr_data_o,
	input  logic                     sdr_wr_next_i,

	// Read path
	input  logic                     sdr_rd_valid_i,
	input  logic [`WB2SDRC_DW-1:0]   sdr_rd_data_i
);

	// One bundle per FIFO
	fifo_if #(.payload_t(sdr_cmd_t)) cmd_q ();
	fifo_if #(.payload_t(wr_beat_t)) wrdata_q ();
	fifo_if #(.payload_t(rd_beat_t)) rddata_q ();

	sdr_cmd_t cmd_head;
	wr_beat_t wr_head;
	rd_beat_t rd_in;

	// ------------------------------------------------------------------------
	// Bus side control
	// ------------------------------------------------------------------------

	wb_slave_ctrl u_slave_ctrl (
		.sdram_clk (sdram_clk),
		.wb_clk_i  (wb_clk_i),
		.wb_stb_i  (wb_stb_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_we_i   (wb_we_i),
		.wb_addr_i (wb_addr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_sel_i  (wb_sel_i),
		.wb_ack_o  (wb_ack_o),
		.wb_dat_o  (wb_dat_o),
		.cmd_q     (cmd_q.producer),
		.wrdata_q  (wrdata_q.producer),
		.rddata_q  (rddata_q.consumer)
	);

	// ------------------------------------------------------------------------
	// Command FIFO
	// ------------------------------------------------------------------------

	sync_fifo #(
		.payload_t (sdr_cmd_t),
		.DEPTH     (`WB2SDRC_CMD_DEPTH)
	) u_cmdfifo (
		.sdram_clk (sdram_clk),
		.wb_clk_i  (wb_clk_i),
		.q         (cmd_q.storage)
	);

	// Request held while anything is queued, ack drops the head
	assign cmd_q.pop      = sdr_req_ack_i;
	assign sdr_req_o      = ~cmd_q.empty;
	assign cmd_head       = cmd_q.pop_data;
	assign sdr_req_addr_o = cmd_head.addr;
	assign sdr_req_wr_n_o = cmd_head.wr_n;

	// ------------------------------------------------------------------------
	// Write data FIFO
	// ------------------------------------------------------------------------

	sync_fifo #(
		.payload_t (wr_beat_t),
		.DEPTH     (`WB2SDRC_WRDATA_DEPTH)
	) u_wrdatafifo (
		.sdram_clk (sdram_clk),
		.wb_clk_i  (wb_clk_i),
		.q         (wrdata_q.storage)
	);

	// Controller takes the head beat and asks for the next
	assign wrdata_q.pop  = sdr_wr_next_i;
	assign wr_head       = wrdata_q.pop_data;
	assign sdr_wr_en_n_o = wr_head.wr_en_n;
	assign sdr_wr_data_o = wr_head.data;

	// ------------------------------------------------------------------------
	// Read data FIFO
	// ------------------------------------------------------------------------

	// One beat per read valid strobe
	assign rd_in.data         = sdr_rd_data_i;
	assign rddata_q.push      = sdr_rd_valid_i;
	assign rddata_q.push_data = rd_in;

	sync_fifo #(
		.payload_t (rd_beat_t),
		.DEPTH     (`WB2SDRC_RDDATA_DEPTH)
	) u_rddatafifo (
		.sdram_clk (sdram_clk),
		.wb_clk_i  (wb_clk_i),
		.q         (rddata_q.storage)
	);

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps
`include "wb2sdrc_config.svh"

// Scoreboard for the bridge, watches the ports and compares
// Table values arrive through the row ports of the current transfer
module tb_checker #(
	parameter int NAME_W = 96
) (
	input  logic                     sdram_clk,
	input  logic                     wb_clk_i,
	input  logic                     wb_stb_i,
	input  logic                     wb_cyc_i,
	input  logic                     wb_we_i,
	input  logic                     wb_ack_o,
	input  logic [`WB2SDRC_DW-1:0]   wb_dat_o,
	input  logic                     sdr_req_o,
	input  logic [`WB2SDRC_AW-1:0]   sdr_req_addr_o,
	input  logic                     sdr_req_wr_n_o,
	input  logic                     sdr_req_ack_i,
	input  logic [`WB2SDRC_DW/8-1:0] sdr_wr_en_n_o,
	input  logic [`WB2SDRC_DW-1:0]   sdr_wr_data_o,
	input  logic                     sdr_wr_next_i,
	// Row currently on the bus
	input  logic [NAME_W-1:0]        row_name_i,
	input  logic [`WB2SDRC_AW-1:0]   row_addr_i,
	input  logic [`WB2SDRC_DW-1:0]   row_data_i,
	input  logic [`WB2SDRC_DW/8-1:0] row_sel_i,
	input  logic                     all_done_i,
	output int                       value_errs_o,
	output int                       proto_errs_o
);

	localparam int DW        = `WB2SDRC_DW;
	localparam int AW        = `WB2SDRC_AW;
	localparam int CMD_DEPTH = `WB2SDRC_CMD_DEPTH;

	// Expected request and write beat, tagged with the row name
	typedef struct packed {
		logic [NAME_W-1:0] name;
		logic              wr_n;
		logic [AW-1:0]     addr;
	} exp_cmd_t;

	typedef struct packed {
		logic [NAME_W-1:0] name;
		logic [DW/8-1:0]   en_n;
		logic [DW-1:0]     data;
	} exp_beat_t;

	exp_cmd_t      cmd_exp [$];
	exp_beat_t     beat_exp [$];
	logic [DW-1:0] model [logic [AW-1:0]];
	logic          rd_open     = 1'b0;
	logic          final_done  = 1'b0;
	int            rst_tail    = 0;
	int            full_stalls = 0;

	initial begin
		value_errs_o = 0;
		proto_errs_o = 0;
	end

	// Untouched words read back a pattern of the whole address
	function automatic logic [DW-1:0] model_read(input logic [AW-1:0] a);
		if (model.exists(a))
			return model[a];
		return (DW'(a) * DW'(32'h9e37_79b1)) ^ DW'(32'h0f1e_2d3c);
	endfunction

	// Selected lanes replaced, others kept
	function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_d,
			input logic [DW-1:0] wdata, input logic [DW/8-1:0] sel);
		logic [DW-1:0] res;
		res = old_d;
		for (int b = 0; b < DW / 8; b++)
			if (sel[b])
				res[8*b +: 8] = wdata[8*b +: 8];
		return res;
	endfunction

	task automatic compare_value(input logic [NAME_W-1:0] name, input string what,
			input logic [63:0] exp_v, input logic [63:0] act_v);
		if (exp_v !== act_v) begin
			value_errs_o++;
			$display("Fail %0s %s: expected %0h actual %0h", name, what, exp_v, act_v);
		end
	endtask

	task automatic protocol_error(input string msg);
		proto_errs_o++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	// ------------------------------------------------------------------------
	// Sampling at the rising edge, same view as the DUT flops
	// ------------------------------------------------------------------------

	always @(posedge sdram_clk) begin
		exp_cmd_t  c;
		exp_beat_t w;
		// Quiet outputs through reset and two cycles after
		if (wb_clk_i || rst_tail < 2) begin
			compare_value("reset", "wb_ack_o", 64'd0, 64'(wb_ack_o));
			compare_value("reset", "sdr_req_o", 64'd0, 64'(sdr_req_o));
			if (!wb_clk_i)
				rst_tail++;
		end else begin
			// Accepted write, queue size still matches the FIFO count here
			if (wb_stb_i && wb_cyc_i && wb_we_i) begin
				if (wb_ack_o) begin
					if (cmd_exp.size() >= CMD_DEPTH)
						protocol_error("write acknowledged with the command FIFO full");
					cmd_exp.push_back('{row_name_i, 1'b0, row_addr_i});
					beat_exp.push_back('{row_name_i, ~row_sel_i, row_data_i});
					model[row_addr_i] = merge_bytes(model_read(row_addr_i), row_data_i, row_sel_i);
				end else if (cmd_exp.size() == CMD_DEPTH) begin
					full_stalls++;
				end
			end
			// One request per read cycle, data checked on the ack
			if (wb_stb_i && wb_cyc_i && !wb_we_i) begin
				if (!rd_open) begin
					cmd_exp.push_back('{row_name_i, 1'b1, row_addr_i});
					rd_open = 1'b1;
				end
				if (wb_ack_o) begin
					compare_value(row_name_i, "wb_dat_o", 64'(model_read(row_addr_i)),
						64'(wb_dat_o));
					rd_open = 1'b0;
				end
			end
			// Request taken by the controller
			if (sdr_req_ack_i) begin
				if (!sdr_req_o || cmd_exp.size() == 0) begin
					protocol_error("request acknowledged with none expected");
				end else begin
					c = cmd_exp.pop_front();
					compare_value(c.name, "sdr_req_addr_o", 64'(c.addr), 64'(sdr_req_addr_o));
					compare_value(c.name, "sdr_req_wr_n_o", 64'(c.wr_n), 64'(sdr_req_wr_n_o));
				end
			end
			// Write beat taken by the controller
			if (sdr_wr_next_i) begin
				if (beat_exp.size() == 0) begin
					protocol_error("write beat taken with none expected");
				end else begin
					w = beat_exp.pop_front();
					compare_value(w.name, "sdr_wr_data_o", 64'(w.data), 64'(sdr_wr_data_o));
					compare_value(w.name, "sdr_wr_en_n_o", 64'(w.en_n), 64'(sdr_wr_en_n_o));
				end
			end
			// Leftovers once the table has run
			if (all_done_i && !final_done) begin
				final_done = 1'b1;
				if (cmd_exp.size() != 0)
					protocol_error("expected requests never reached the controller");
				if (beat_exp.size() != 0)
					protocol_error("expected write beats never reached the controller");
				if (full_stalls == 0)
					protocol_error("command FIFO never filled, back-pressure not exercised");
			end
		end
	end

endmodule

//--- tb_wb2sdrc.sv
`timescale 1ns/1ps
`include "wb2sdrc_config.svh"

// Testbench top for the Wishbone to SDRAM request bridge
module tb_wb2sdrc
	import sdr_cmd_pkg::*;
	import sdr_data_pkg::*;
();

	localparam int DW             = `WB2SDRC_DW;
	localparam int AW             = `WB2SDRC_AW;
	localparam int NAME_W         = 96;
	localparam int NROWS          = 16;
	localparam int RST_CYCLES     = 16;
	localparam int TIMEOUT_CYCLES = RST_CYCLES + NROWS * 48;
	// Acks withheld this long while stall rows run
	localparam int STALL_LEN      = 40;

	// One bus transfer per row
	// Stall rows freeze the controller
	typedef struct packed {
		logic [NAME_W-1:0] name;
		logic              we;
		logic [AW-1:0]     addr;
		logic [DW-1:0]     data;
		logic [DW/8-1:0]   sel;
		logic              stall;
	} row_t;

	// Reads carry no data or sel
	row_t tbl [NROWS] = '{
		'{"wr_full",    1'b1, 'h000_0010, 'h1122_3344, 'hf, 1'b0},
		'{"rd_full",    1'b0, 'h000_0010, 'h0,         'h0, 1'b0},
		'{"wr_lo_half", 1'b1, 'h000_0010, 'haabb_ccdd, 'h3, 1'b0},
		'{"rd_merge",   1'b0, 'h000_0010, 'h0,         'h0, 1'b0},
		'{"rd_fill",    1'b0, 'h2a5_5a5c, 'h0,         'h0, 1'b0},
		'{"wr_byte2",   1'b1, 'h3ff_fff0, 'hdead_beef, 'h4, 1'b0},
		'{"rd_byte2",   1'b0, 'h3ff_fff0, 'h0,         'h0, 1'b0},
		'{"stall_wr0",  1'b1, 'h000_0100, 'h0101_0101, 'hf, 1'b1},
		'{"stall_wr1",  1'b1, 'h000_0101, 'h0202_0202, 'hc, 1'b1},
		'{"stall_wr2",  1'b1, 'h000_0102, 'h0303_0303, 'hf, 1'b1},
		'{"stall_wr3",  1'b1, 'h000_0103, 'h0404_0404, 'h9, 1'b1},
		'{"stall_wr4",  1'b1, 'h000_0104, 'h0505_0505, 'hf, 1'b1},
		'{"stall_wr5",  1'b1, 'h000_0100, 'h0606_0606, 'h2, 1'b1},
		'{"rd_stall3",  1'b0, 'h000_0103, 'h0,         'h0, 1'b0},
		'{"wr_odd",     1'b1, 'h000_0104, 'h5566_7788, 'h5, 1'b0},
		'{"rd_odd",     1'b0, 'h000_0104, 'h0,         'h0, 1'b0}
	};

	// DUT ports
	logic                sdram_clk = 1'b1;
	logic                wb_clk_i;
	logic                wb_stb_i;
	logic                wb_cyc_i;
	logic                wb_we_i;
	logic [AW-1:0]       wb_addr_i;
	logic [DW-1:0]       wb_dat_i;
	logic [DW/8-1:0]     wb_sel_i;
	logic                wb_ack_o;
	logic [DW-1:0]       wb_dat_o;
	logic                sdr_req_o;
	logic                sdr_req_wr_n_o;
	logic                sdr_req_ack_i;
	logic [AW-1:0]       sdr_req_addr_o;
	logic [DW/8-1:0]     sdr_wr_en_n_o;
	logic [DW-1:0]       sdr_wr_data_o;
	logic [DW-1:0]       sdr_rd_data_i;
	logic                sdr_wr_next_i;
	logic                sdr_rd_valid_i;

	// Row fields for the checker
	logic [NAME_W-1:0]   row_name = '0;
	logic [AW-1:0]       row_addr = '0;
	logic [DW-1:0]       row_data = '0;
	logic [DW/8-1:0]     row_sel = '0;
	logic                cur_stall = 1'b0;
	logic                stall_seen = 1'b0;
	logic                all_done = 1'b0;
	logic                resp_busy = 1'b0;
	int                  stall_cycles = 0;
	int                  cycle_cnt = 0;
	int                  value_errs;
	int                  proto_errs;
	logic [31:0]         lfsr_state = 32'h1c30_90b7;
	logic [DW-1:0]       sdram_mem [logic [AW-1:0]];

	always #5 sdram_clk = ~sdram_clk;

	wb2sdrc i_dut (.*);

	tb_checker #(.NAME_W(NAME_W)) u_checker (
		.*,
		.row_name_i   (row_name),
		.row_addr_i   (row_addr),
		.row_data_i   (row_data),
		.row_sel_i    (row_sel),
		.all_done_i   (all_done),
		.value_errs_o (value_errs),
		.proto_errs_o (proto_errs)
	);

	// Galois LFSR stepped once per bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return bits;
	endfunction

	// Unwritten controller words hold an address pattern
	function automatic logic [DW-1:0] mem_read(input logic [AW-1:0] a);
		if (sdram_mem.exists(a))
			return sdram_mem[a];
		return (DW'(a) * DW'(32'h9e37_79b1)) ^ DW'(32'h0f1e_2d3c);
	endfunction

	// Hold one transfer until the ack and step to the next falling edge
	task automatic drive_row(input row_t r);
		row_name  = r.name;
		row_addr  = r.addr;
		row_data  = r.data;
		row_sel   = r.sel;
		cur_stall = r.stall;
		wb_stb_i  = 1'b1;
		wb_cyc_i  = 1'b1;
		wb_we_i   = r.we;
		wb_addr_i = r.addr;
		wb_dat_i  = r.data;
		wb_sel_i  = r.sel;
		do @(posedge sdram_clk); while (wb_ack_o !== 1'b1);
		@(negedge sdram_clk);
	endtask

	task automatic report_and_finish(input bit timed_out);
		$display("errors: %0d value, %0d protocol", value_errs, proto_errs);
		if (!timed_out && value_errs == 0 && proto_errs == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	// ------------------------------------------------------------------------
	// Bus master
	// ------------------------------------------------------------------------

	initial begin : master
		wb_clk_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_cyc_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_addr_i = '0;
		wb_dat_i  = '0;
		wb_sel_i  = '0;
		@(negedge sdram_clk);
		wb_clk_i = 1'b1;
		repeat (RST_CYCLES) @(posedge sdram_clk);
		@(negedge sdram_clk);
		wb_clk_i = 1'b0;
		repeat (2) @(negedge sdram_clk);
		foreach (tbl[i])
			drive_row(tbl[i]);
		wb_stb_i  = 1'b0;
		wb_cyc_i  = 1'b0;
		cur_stall = 1'b0;
		// Drain whatever the controller still holds
		do @(posedge sdram_clk); while (sdr_req_o || resp_busy);
		@(negedge sdram_clk);
		all_done = 1'b1;
		repeat (2) @(posedge sdram_clk);
		report_and_finish(1'b0);
	end

	// ------------------------------------------------------------------------
	// SDRAM controller model taking one command at a time
	// ------------------------------------------------------------------------

	always @(posedge sdram_clk) stall_seen <= cur_stall;

	initial begin : responder
		logic [AW-1:0] addr;
		logic [DW-1:0] word;
		logic          is_read;
		int            delay;
		sdr_req_ack_i  = 1'b0;
		sdr_wr_next_i  = 1'b0;
		sdr_rd_valid_i = 1'b0;
		sdr_rd_data_i  = '0;
		wait (wb_clk_i === 1'b1);
		@(negedge wb_clk_i);
		forever begin
			@(negedge sdram_clk);
			if (sdr_req_o) begin
				resp_busy = 1'b1;
				delay = int'(take_bits(2));
				repeat (delay) @(negedge sdram_clk);
				// Freeze while stall rows fill the command FIFO
				while (stall_seen && stall_cycles < STALL_LEN) begin
					stall_cycles++;
					@(negedge sdram_clk);
				end
				addr          = sdr_req_addr_o;
				is_read       = sdr_req_wr_n_o;
				sdr_req_ack_i = 1'b1;
				@(negedge sdram_clk);
				sdr_req_ack_i = 1'b0;
				if (is_read) begin
					delay = 1 + int'(take_bits(2));
					repeat (delay) @(negedge sdram_clk);
					sdr_rd_data_i  = mem_read(addr);
					sdr_rd_valid_i = 1'b1;
				end else begin
					// Only enabled lanes land in memory
					word = mem_read(addr);
					for (int b = 0; b < DW / 8; b++)
						if (!sdr_wr_en_n_o[b])
							word[8*b +: 8] = sdr_wr_data_o[8*b +: 8];
					sdram_mem[addr] = word;
					sdr_wr_next_i   = 1'b1;
				end
				@(negedge sdram_clk);
				sdr_rd_valid_i = 1'b0;
				sdr_wr_next_i  = 1'b0;
				resp_busy      = 1'b0;
			end
		end
	end

	// Run limit scaled by table length
	initial begin : watchdog
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge sdram_clk);
			cycle_cnt++;
		end
		$display("Error: timeout, table not finished after %0d cycles", cycle_cnt);
		report_and_finish(1'b1);
	end

endmodule

//--- wb2sdrc.f
+incdir+.
sdr_cmd_pkg.sv
sdr_data_pkg.sv
fifo_if.sv
sync_fifo.sv
wb_slave_ctrl.sv
wb2sdrc.sv
tb_checker.sv
tb_wb2sdrc.sv
